/* rtl/addr_translate.sv */
// fetch and data address translation, segment decode, tlb exceptions, registered responses

`timescale 1ns/1ps

module addr_translate (
    input  logic               clk,
    input  logic               rst_n,
    input  mmu_pkg::xlat_req_t inst_req,
    input  mmu_pkg::xlat_req_t data_req,
    output mmu_pkg::xlat_rsp_t inst_rsp,
    output mmu_pkg::xlat_rsp_t data_rsp,
    input  logic               tlbp_active,
    input  mmu_pkg::vpn2_t     probe_vpn2,
    output mmu_pkg::vpn2_t     s0_vpn2,
    output logic               s0_odd,
    output mmu_pkg::vpn2_t     s1_vpn2,
    output logic               s1_odd,
    input  logic               s0_found,
    input  logic               s1_found,
    input  mmu_pkg::tlb_page_t s0_page,
    input  mmu_pkg::tlb_page_t s1_page
);

    mmu_pkg::xlat_rsp_t inst_next;
    mmu_pkg::xlat_rsp_t data_next;

    function automatic mmu_pkg::xlat_rsp_t xlate(mmu_pkg::xlat_req_t req, logic found,
                                                 mmu_pkg::tlb_page_t page);
        mmu_pkg::xlat_rsp_t rsp;
        rsp.valid  = req.valid;
        rsp.paddr  = '0;
        rsp.cached = 1'b0;
        rsp.exc    = mmu_pkg::exc_none;
        if (req.vaddr >= mmu_pkg::kseg1_base && req.vaddr < mmu_pkg::kseg2_base) begin
            rsp.paddr = req.vaddr - mmu_pkg::kseg1_base;   // kseg1, uncached
        end else if (req.vaddr >= mmu_pkg::kseg0_base && req.vaddr < mmu_pkg::kseg1_base) begin
            rsp.paddr  = req.vaddr - mmu_pkg::kseg0_base;
            rsp.cached = 1'b1;
        end else if (!found) begin
            rsp.exc = mmu_pkg::exc_refill;
        end else if (!page.v) begin
            rsp.exc = mmu_pkg::exc_invalid;
        end else if (req.store && !page.d) begin
            rsp.exc = mmu_pkg::exc_modified;
        end else begin
            rsp.paddr  = {page.pfn, req.vaddr[11:0]};
            rsp.cached = page.c == mmu_pkg::cache_c_cached;
        end
        return rsp;
    endfunction

    assign s0_vpn2 = inst_req.vaddr[31:13];
    assign s0_odd  = inst_req.vaddr[12];
    // port 1 lent to the probe while tlbp runs
    assign s1_vpn2 = tlbp_active ? probe_vpn2 : data_req.vaddr[31:13];
    assign s1_odd  = data_req.vaddr[12];

    assign inst_next = xlate(inst_req, s0_found, s0_page);
    assign data_next = xlate(data_req, s1_found, s1_page);

    always_ff @(posedge clk) begin
        inst_rsp <= inst_next;
        data_rsp <= data_next;
        if (!rst_n) begin
            inst_rsp.valid <= 1'b0;
            data_rsp.valid <= 1'b0;
        end
    end

endmodule

/* rtl/cp0_tlb_regs.sv */
// cp0 tlb registers behind a wishbone classic slave, runs tlbp, tlbr and tlbwi

`timescale 1ns/1ps

module cp0_tlb_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  wb_pkg::wb_req_t     wb_req,
    output wb_pkg::wb_rsp_t     wb_rsp,
    output mmu_pkg::asid_t      asid,
    output logic                tlbp_active,
    output mmu_pkg::vpn2_t      probe_vpn2,
    input  logic                probe_found,
    input  logic [3:0]          probe_index,
    output logic                tlb_we,
    output logic [3:0]          tlb_index,
    output mmu_pkg::tlb_entry_t tlb_w_entry,
    input  mmu_pkg::tlb_entry_t tlb_r_entry
);

    logic              ack_q;
    logic              index_p;     // probe failure flag, bit 31
    logic [3:0]        index_val;
    mmu_pkg::entryhi_t entryhi_q;
    mmu_pkg::entrylo_t entrylo0_q;
    mmu_pkg::entrylo_t entrylo1_q;
    mmu_pkg::cp0_word_u wdat;
    logic              wr_ack;
    logic              cmd_wr;
    logic              do_tlbr;

    assign wdat    = wb_req.dat_w;
    assign wr_ack  = ack_q && wb_req.cyc && wb_req.stb && wb_req.we;
    assign cmd_wr  = wr_ack && wb_req.adr == wb_pkg::reg_cmd;

    // commands execute in the ack cycle
    assign tlbp_active = cmd_wr && wb_req.dat_w == wb_pkg::cmd_tlbp;
    assign do_tlbr     = cmd_wr && wb_req.dat_w == wb_pkg::cmd_tlbr;
    assign tlb_we      = cmd_wr && wb_req.dat_w == wb_pkg::cmd_tlbwi;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_req.cyc && wb_req.stb && !ack_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index_p    <= 1'b0;
            index_val  <= '0;
            entryhi_q  <= '0;
            entrylo0_q <= '0;
            entrylo1_q <= '0;
        end else begin
            if (wr_ack) begin
                case (wb_req.adr)
                    wb_pkg::reg_index: begin
                        index_p   <= 1'b0;
                        index_val <= wb_req.dat_w[3:0];
                    end
                    wb_pkg::reg_entryhi: begin
                        entryhi_q <= '{vpn2: wdat.hi.vpn2, rsvd: '0, asid: wdat.hi.asid};
                    end
                    wb_pkg::reg_entrylo0: begin
                        entrylo0_q <= '{rsvd: '0, pfn: wdat.lo.pfn, c: wdat.lo.c,
                                        d: wdat.lo.d, v: wdat.lo.v, g: wdat.lo.g};
                    end
                    wb_pkg::reg_entrylo1: begin
                        entrylo1_q <= '{rsvd: '0, pfn: wdat.lo.pfn, c: wdat.lo.c,
                                        d: wdat.lo.d, v: wdat.lo.v, g: wdat.lo.g};
                    end
                    default: ;   // reg_cmd handled below
                endcase
            end
            if (tlbp_active) begin
                index_p   <= !probe_found;
                index_val <= probe_found ? probe_index : 4'd0;
            end
            if (do_tlbr) begin
                entryhi_q  <= '{vpn2: tlb_r_entry.vpn2, rsvd: '0, asid: tlb_r_entry.asid};
                // stored g shows up in both lo words
                entrylo0_q <= '{rsvd: '0, pfn: tlb_r_entry.page0.pfn, c: tlb_r_entry.page0.c,
                                d: tlb_r_entry.page0.d, v: tlb_r_entry.page0.v,
                                g: tlb_r_entry.g};
                entrylo1_q <= '{rsvd: '0, pfn: tlb_r_entry.page1.pfn, c: tlb_r_entry.page1.c,
                                d: tlb_r_entry.page1.d, v: tlb_r_entry.page1.v,
                                g: tlb_r_entry.g};
            end
        end
    end

    always_comb begin
        wb_rsp.ack = ack_q;
        case (wb_req.adr)
            wb_pkg::reg_index:    wb_rsp.dat_r = {index_p, 27'b0, index_val};
            wb_pkg::reg_entryhi:  wb_rsp.dat_r = entryhi_q;
            wb_pkg::reg_entrylo0: wb_rsp.dat_r = entrylo0_q;
            wb_pkg::reg_entrylo1: wb_rsp.dat_r = entrylo1_q;
            default:              wb_rsp.dat_r = '0;   // cmd reads as zero
        endcase
    end

    assign asid       = entryhi_q.asid;
    assign probe_vpn2 = entryhi_q.vpn2;
    assign tlb_index  = index_val;

    always_comb begin
        tlb_w_entry.vpn2  = entryhi_q.vpn2;
        tlb_w_entry.asid  = entryhi_q.asid;
        tlb_w_entry.g     = entrylo0_q.g & entrylo1_q.g;
        tlb_w_entry.page0 = '{pfn: entrylo0_q.pfn, c: entrylo0_q.c,
                              d: entrylo0_q.d, v: entrylo0_q.v};
        tlb_w_entry.page1 = '{pfn: entrylo1_q.pfn, c: entrylo1_q.c,
                              d: entrylo1_q.d, v: entrylo1_q.v};
    end

endmodule

/* rtl/mmu_pkg.sv */
// mmu types: tlb entry and page, cp0 word union, translation request/response, exception codes

package mmu_pkg;

    localparam int tlb_entries = 16;

    // unmapped segment boundaries
    localparam logic [31:0] kseg0_base = 32'h8000_0000;
    localparam logic [31:0] kseg1_base = 32'hA000_0000;
    localparam logic [31:0] kseg2_base = 32'hC000_0000;

    localparam logic [2:0] cache_c_cached = 3'd3;

    typedef logic [18:0] vpn2_t;   // vaddr[31:13]
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;

    typedef struct packed {
        pfn_t       pfn;
        logic [2:0] c;
        logic       d;
        logic       v;
    } tlb_page_t;

    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;   // even page
        tlb_page_t page1;   // odd page
    } tlb_entry_t;

    typedef struct packed {
        vpn2_t      vpn2;
        logic [4:0] rsvd;
        asid_t      asid;
    } entryhi_t;

    typedef struct packed {
        logic [5:0] rsvd;
        pfn_t       pfn;
        logic [2:0] c;
        logic       d;
        logic       v;
        logic       g;
    } entrylo_t;

    // one bus word, decoded by register address
    typedef union packed {
        entryhi_t hi;
        entrylo_t lo;
    } cp0_word_u;

    typedef enum logic [1:0] {
        exc_none     = 2'd0,
        exc_refill   = 2'd1,
        exc_invalid  = 2'd2,
        exc_modified = 2'd3
    } exc_t;

    typedef struct packed {
        logic        valid;
        logic        store;
        logic [31:0] vaddr;
    } xlat_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        logic        cached;
        exc_t        exc;
    } xlat_rsp_t;

endpackage

/* rtl/mmu_top.sv */
// mmu top level: cp0 register block, tlb array and translation stage

`timescale 1ns/1ps

module mmu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  wb_pkg::wb_req_t    wb_req,
    output wb_pkg::wb_rsp_t    wb_rsp,
    input  mmu_pkg::xlat_req_t inst_req,
    input  mmu_pkg::xlat_req_t data_req,
    output mmu_pkg::xlat_rsp_t inst_rsp,
    output mmu_pkg::xlat_rsp_t data_rsp
);

    mmu_pkg::asid_t      asid;
    logic                tlbp_active;
    mmu_pkg::vpn2_t      probe_vpn2;
    logic                tlb_we;
    logic [3:0]          tlb_index;
    mmu_pkg::tlb_entry_t tlb_w_entry;
    mmu_pkg::tlb_entry_t tlb_r_entry;
    mmu_pkg::vpn2_t      s0_vpn2;
    mmu_pkg::vpn2_t      s1_vpn2;
    logic                s0_odd;
    logic                s1_odd;
    logic                s0_found;
    logic                s1_found;
    logic [3:0]          s1_index;
    mmu_pkg::tlb_page_t  s0_page;
    mmu_pkg::tlb_page_t  s1_page;

    cp0_tlb_regs cp0_tlb_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .asid        (asid),
        .tlbp_active (tlbp_active),
        .probe_vpn2  (probe_vpn2),
        .probe_found (s1_found),    // probe rides on search port 1
        .probe_index (s1_index),
        .tlb_we      (tlb_we),
        .tlb_index   (tlb_index),
        .tlb_w_entry (tlb_w_entry),
        .tlb_r_entry (tlb_r_entry)
    );

    tlb tlb_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .s0_vpn2  (s0_vpn2),
        .s0_odd   (s0_odd),
        .s1_vpn2  (s1_vpn2),
        .s1_odd   (s1_odd),
        .asid     (asid),
        .s0_found (s0_found),
        .s1_found (s1_found),
        .s0_index (),
        .s1_index (s1_index),
        .s0_page  (s0_page),
        .s1_page  (s1_page),
        .we       (tlb_we),
        .w_index  (tlb_index),
        .w_entry  (tlb_w_entry),
        .r_index  (tlb_index),
        .r_entry  (tlb_r_entry)
    );

    addr_translate addr_translate_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_req    (inst_req),
        .data_req    (data_req),
        .inst_rsp    (inst_rsp),
        .data_rsp    (data_rsp),
        .tlbp_active (tlbp_active),
        .probe_vpn2  (probe_vpn2),
        .s0_vpn2     (s0_vpn2),
        .s0_odd      (s0_odd),
        .s1_vpn2     (s1_vpn2),
        .s1_odd      (s1_odd),
        .s0_found    (s0_found),
        .s1_found    (s1_found),
        .s0_page     (s0_page),
        .s1_page     (s1_page)
    );

endmodule

/* rtl/tlb.sv */
// joint tlb: entry array, two parallel search ports, indexed write and read

`timescale 1ns/1ps

module tlb (
    input  logic                clk,
    input  logic                rst_n,
    input  mmu_pkg::vpn2_t      s0_vpn2,
    input  logic                s0_odd,
    input  mmu_pkg::vpn2_t      s1_vpn2,
    input  logic                s1_odd,
    input  mmu_pkg::asid_t      asid,
    output logic                s0_found,
    output logic                s1_found,
    output logic [3:0]          s0_index,
    output logic [3:0]          s1_index,
    output mmu_pkg::tlb_page_t  s0_page,
    output mmu_pkg::tlb_page_t  s1_page,
    input  logic                we,
    input  logic [3:0]          w_index,
    input  mmu_pkg::tlb_entry_t w_entry,
    input  logic [3:0]          r_index,
    output mmu_pkg::tlb_entry_t r_entry
);

    mmu_pkg::tlb_entry_t entries [mmu_pkg::tlb_entries];

    // search ports folded into arrays so both share one compare loop
    mmu_pkg::vpn2_t     s_vpn2  [2];
    logic               s_odd   [2];
    logic               s_found [2];
    logic [3:0]         s_index [2];
    mmu_pkg::tlb_page_t s_page  [2];

    assign s_vpn2[0] = s0_vpn2;
    assign s_vpn2[1] = s1_vpn2;
    assign s_odd[0]  = s0_odd;
    assign s_odd[1]  = s1_odd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < mmu_pkg::tlb_entries; i++) begin
                entries[i].g       <= 1'b0;
                entries[i].page0.v <= 1'b0;
                entries[i].page0.d <= 1'b0;
                entries[i].page1.v <= 1'b0;
                entries[i].page1.d <= 1'b0;
            end
        end else if (we) begin
            entries[w_index] <= w_entry;
        end
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            s_found[p] = 1'b0;
            s_index[p] = '0;
            s_page[p]  = '0;
            for (int i = 0; i < mmu_pkg::tlb_entries; i++) begin
                // global entries ignore asid
                if (entries[i].vpn2 == s_vpn2[p] &&
                    (entries[i].g || entries[i].asid == asid)) begin
                    s_found[p] = 1'b1;
                    s_index[p] = 4'(i);
                    s_page[p]  = s_odd[p] ? entries[i].page1 : entries[i].page0;
                end
            end
        end
    end

    assign s0_found = s_found[0];
    assign s1_found = s_found[1];
    assign s0_index = s_index[0];
    assign s1_index = s_index[1];
    assign s0_page  = s_page[0];
    assign s1_page  = s_page[1];

    assign r_entry = entries[r_index];

endmodule

/* rtl/wb_pkg.sv */
// wishbone classic request/response structs, cp0 register addresses and command codes

package wb_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    localparam logic [2:0] reg_index    = 3'd0;
    localparam logic [2:0] reg_entryhi  = 3'd1;
    localparam logic [2:0] reg_entrylo0 = 3'd2;
    localparam logic [2:0] reg_entrylo1 = 3'd3;
    localparam logic [2:0] reg_cmd      = 3'd4;

    localparam logic [31:0] cmd_tlbp  = 32'd1;
    localparam logic [31:0] cmd_tlbr  = 32'd2;
    localparam logic [31:0] cmd_tlbwi = 32'd3;

endpackage

/* sim.f */
rtl/mmu_pkg.sv
rtl/wb_pkg.sv
rtl/tlb.sv
rtl/cp0_tlb_regs.sv
rtl/addr_translate.sv
rtl/mmu_top.sv
tb/mmu_properties.sv
tb/tb_mmu.sv

/* tb/mmu_properties.sv */
// bound checks: wishbone ack timing, data port idle during bus cycles, response timing

`timescale 1ns/1ps

module mmu_properties (
    input logic               clk,
    input logic               rst_n,
    input wb_pkg::wb_req_t    wb_req,
    input wb_pkg::wb_rsp_t    wb_rsp,
    input mmu_pkg::xlat_req_t inst_req,
    input mmu_pkg::xlat_req_t data_req,
    input mmu_pkg::xlat_rsp_t inst_rsp,
    input mmu_pkg::xlat_rsp_t data_rsp
);

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("wishbone ack held for more than one cycle");

    ack_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("wishbone ack without a preceding cyc and stb");

    ack_follows_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.cyc && wb_req.stb && !wb_rsp.ack |=> wb_rsp.ack)
        else $error("wishbone ack missing one cycle after cyc and stb");

    // search port 1 may be taken by a probe while a bus cycle is open
    data_idle_in_bus_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_req.cyc && data_req.valid))
        else $error("data request valid while a wishbone cycle is open");

    inst_rsp_timing: assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> inst_rsp.valid == $past(inst_req.valid))
        else $error("fetch response valid does not follow its request");

    data_rsp_timing: assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> data_rsp.valid == $past(data_req.valid))
        else $error("data response valid does not follow its request");

    quiet_after_reset: assert property (@(posedge clk)
        !rst_n |=> !inst_rsp.valid && !data_rsp.valid && !wb_rsp.ack)
        else $error("response valid or ack high right after reset");

endmodule

bind mmu_top mmu_properties mmu_properties_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .inst_req (inst_req),
    .data_req (data_req),
    .inst_rsp (inst_rsp),
    .data_rsp (data_rsp)
);

/* tb/tb_mmu.sv */
// mmu testbench: wishbone master, lfsr stimulus, shadow tlb and cp0 model, response checker

`timescale 1ns/1ps

module tb_mmu;

    localparam int n_unmapped   = 300;
    localparam int n_reg_loops  = 20;
    localparam int n_rounds     = 8;
    localparam int n_round_reqs = 80;
    localparam int n_reads      = 16;
    localparam int n_probes     = 16;
    localparam int n_b2b        = 300;
    localparam int wb_cost      = 3;   // cycles per bus transfer incl. idle
    localparam int planned_cycles = 16 + n_unmapped + n_reg_loops * 9 * wb_cost
        + 16 * 5 * wb_cost + n_rounds * (n_round_reqs + 7 * wb_cost)
        + n_reads * 5 * wb_cost + n_probes * 6 * wb_cost + n_b2b + 10;
    localparam int timeout_cycles = 2 * planned_cycles;

    logic               clk;
    logic               rst_n;
    wb_pkg::wb_req_t    wb_req;
    wb_pkg::wb_rsp_t    wb_rsp;
    mmu_pkg::xlat_req_t inst_req;
    mmu_pkg::xlat_req_t data_req;
    mmu_pkg::xlat_rsp_t inst_rsp;
    mmu_pkg::xlat_rsp_t data_rsp;

    logic [15:0]         lfsr_state;
    int                  cycle_count;
    int                  check_count;
    int                  error_count;
    int                  fault_count;
    mmu_pkg::xlat_rsp_t  inst_exp [$];
    mmu_pkg::xlat_rsp_t  data_exp [$];
    mmu_pkg::xlat_rsp_t  exp_rsp;
    mmu_pkg::vpn2_t      hi_vpn2;
    logic [1:0]          hi_asid;

    // shadow state
    mmu_pkg::tlb_entry_t sh_tlb [16];
    logic                sh_written [16];
    logic [3:0]          sh_index;
    logic                sh_index_fail;
    mmu_pkg::entryhi_t   sh_hi;
    mmu_pkg::entrylo_t   sh_lo0;
    mmu_pkg::entrylo_t   sh_lo1;

    mmu_top mmu_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .inst_req (inst_req),
        .data_req (data_req),
        .inst_rsp (inst_rsp),
        .data_rsp (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic int tlb_search(input mmu_pkg::vpn2_t vpn2, input mmu_pkg::asid_t asid);
        int hit;
        hit = -1;
        for (int i = 0; i < 16; i++) begin
            if (sh_written[i] && sh_tlb[i].vpn2 == vpn2 && (sh_tlb[i].g || sh_tlb[i].asid == asid))
                hit = i;
        end
        return hit;
    endfunction

    function automatic mmu_pkg::xlat_rsp_t model_xlat(input logic store, input logic [31:0] va);
        mmu_pkg::xlat_rsp_t r;
        mmu_pkg::tlb_page_t pg;
        int hit;
        r = '0;
        r.valid = 1'b1;
        r.exc = mmu_pkg::exc_none;
        if (va[31:30] == 2'b10) begin
            r.paddr = {3'b000, va[28:0]};   // kseg0 and kseg1 both land in low 512 MB
            r.cached = !va[29];
            return r;
        end
        hit = tlb_search(va[31:13], sh_hi.asid);
        if (hit < 0) begin
            r.exc = mmu_pkg::exc_refill;
            return r;
        end
        pg = va[12] ? sh_tlb[hit].page1 : sh_tlb[hit].page0;
        if (!pg.v) begin
            r.exc = mmu_pkg::exc_invalid;
        end else if (store && !pg.d) begin
            r.exc = mmu_pkg::exc_modified;
        end else begin
            r.paddr = {pg.pfn, va[11:0]};
            r.cached = pg.c == mmu_pkg::cache_c_cached;
        end
        return r;
    endfunction

    function automatic mmu_pkg::vpn2_t random_vpn2(input logic [3:0] idx);
        mmu_pkg::vpn2_t v;
        v = rand_bits(19);
        v[3:0] = idx;   // low nibble tags the entry so no two entries match
        if (v[18:17] == 2'b10)
            v[17] = 1'b1;
        return v;
    endfunction

    function automatic logic [31:0] unmapped_addr();
        logic [29:0] low;
        low = rand_bits(30);
        return {2'b10, low};
    endfunction

    function automatic logic [31:0] pick_addr();
        logic [3:0]     i;
        logic [12:0]    off;
        mmu_pkg::vpn2_t vpn2;
        if (rand_bits(2) == 0)
            return unmapped_addr();
        i = rand_bits(4);
        if (rand_bits(3) != 0)
            vpn2 = sh_tlb[i].vpn2;
        else
            vpn2 = random_vpn2(rand_bits(4));
        off = rand_bits(13);
        return {vpn2, off};
    endfunction

    task automatic wb_cycle(input logic we, input logic [2:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat};
        do begin
            @(negedge clk);
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat_r;
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic reg_write(input logic [2:0] adr, input logic [31:0] dat);
        logic [31:0]        rd_ignored;
        mmu_pkg::cp0_word_u w;
        mmu_pkg::tlb_entry_t e;
        int                 hit;
        wb_cycle(1'b1, adr, dat, rd_ignored);
        w = dat;
        e = sh_tlb[sh_index];
        case (adr)
            wb_pkg::reg_index: begin
                sh_index = dat[3:0];
                sh_index_fail = 1'b0;
            end
            wb_pkg::reg_entryhi: begin
                sh_hi = w.hi;
                sh_hi.rsvd = '0;
            end
            wb_pkg::reg_entrylo0: begin
                sh_lo0 = w.lo;
                sh_lo0.rsvd = '0;
            end
            wb_pkg::reg_entrylo1: begin
                sh_lo1 = w.lo;
                sh_lo1.rsvd = '0;
            end
            default: begin
                if (dat == wb_pkg::cmd_tlbp) begin
                    hit = tlb_search(sh_hi.vpn2, sh_hi.asid);
                    sh_index_fail = hit < 0;
                    sh_index = (hit >= 0) ? hit[3:0] : 4'd0;
                end else if (dat == wb_pkg::cmd_tlbr) begin
                    sh_hi = '{vpn2: e.vpn2, rsvd: '0, asid: e.asid};
                    sh_lo0 = '{rsvd: '0, pfn: e.page0.pfn, c: e.page0.c,
                               d: e.page0.d, v: e.page0.v, g: e.g};
                    sh_lo1 = '{rsvd: '0, pfn: e.page1.pfn, c: e.page1.c,
                               d: e.page1.d, v: e.page1.v, g: e.g};
                end else if (dat == wb_pkg::cmd_tlbwi) begin
                    e.vpn2 = sh_hi.vpn2;
                    e.asid = sh_hi.asid;
                    e.g = sh_lo0.g & sh_lo1.g;   // global only if both halves say so
                    e.page0 = '{pfn: sh_lo0.pfn, c: sh_lo0.c, d: sh_lo0.d, v: sh_lo0.v};
                    e.page1 = '{pfn: sh_lo1.pfn, c: sh_lo1.c, d: sh_lo1.d, v: sh_lo1.v};
                    sh_tlb[sh_index] = e;
                    sh_written[sh_index] = 1'b1;
                end
            end
        endcase
    endtask

    task automatic reg_read_check(input logic [2:0] adr, input string what);
        logic [31:0] got;
        logic [31:0] exp;
        wb_cycle(1'b0, adr, 32'h0, got);
        case (adr)
            wb_pkg::reg_index:    exp = {sh_index_fail, 27'b0, sh_index};
            wb_pkg::reg_entryhi:  exp = sh_hi;
            wb_pkg::reg_entrylo0: exp = sh_lo0;
            wb_pkg::reg_entrylo1: exp = sh_lo1;
            default:              exp = '0;
        endcase
        check_value(got, exp, what);
    endtask

    task automatic write_entry(input logic [3:0] i);
        mmu_pkg::vpn2_t vpn2;
        logic [1:0]     asid;
        vpn2 = random_vpn2(i);
        asid = rand_bits(2);   // small asid set so matches happen
        reg_write(wb_pkg::reg_index, {28'b0, i});
        reg_write(wb_pkg::reg_entryhi, {vpn2, 11'b0, asid});
        reg_write(wb_pkg::reg_entrylo0, rand_bits(32));
        reg_write(wb_pkg::reg_entrylo1, rand_bits(32));
        reg_write(wb_pkg::reg_cmd, wb_pkg::cmd_tlbwi);
    endtask

    task automatic probe_check(input logic [3:0] i, input logic present);
        logic [31:0]    got;
        mmu_pkg::vpn2_t vpn2;
        vpn2 = present ? sh_tlb[i].vpn2 : sh_tlb[i].vpn2 ^ 19'h400;
        reg_write(wb_pkg::reg_entryhi, {vpn2, 5'b0, sh_tlb[i].asid});
        reg_write(wb_pkg::reg_cmd, wb_pkg::cmd_tlbp);
        wb_cycle(1'b0, wb_pkg::reg_index, 32'h0, got);
        check_value(got[31], sh_index_fail, "probe miss flag");
        if (!sh_index_fail)
            check_value(got[3:0], sh_index, "probe index");
    endtask

    task automatic drive_pair(input logic iv, input logic [31:0] iva, input logic dv,
                              input logic ds, input logic [31:0] dva);
        @(posedge clk);
        inst_req <= '{valid: iv, store: 1'b0, vaddr: iva};
        data_req <= '{valid: dv, store: ds, vaddr: dva};
        if (iv)
            inst_exp.push_back(model_xlat(1'b0, iva));
        if (dv)
            data_exp.push_back(model_xlat(ds, dva));
    endtask

    always @(negedge clk) begin
        if (inst_rsp.valid === 1'b1) begin
            if (inst_exp.size() == 0) begin
                fault_count++;
                $display("fetch response at %0t ns with no request outstanding", $time);
            end else begin
                exp_rsp = inst_exp.pop_front();
                check_value(inst_rsp, exp_rsp, "fetch translation");
            end
        end
        if (data_rsp.valid === 1'b1) begin
            if (data_exp.size() == 0) begin
                fault_count++;
                $display("data response at %0t ns with no request outstanding", $time);
            end else begin
                exp_rsp = data_exp.pop_front();
                check_value(data_rsp, exp_rsp, "data translation");
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run hung: still going after %0d cycles", timeout_cycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        lfsr_state = 16'd63725;
        check_count = 0;
        error_count = 0;
        fault_count = 0;
        rst_n = 1'b0;
        wb_req = '0;
        inst_req = '0;
        data_req = '0;
        sh_index = '0;
        sh_index_fail = 1'b0;
        sh_hi = '0;
        sh_lo0 = '0;
        sh_lo1 = '0;
        for (int i = 0; i < 16; i++)
            sh_written[i] = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // unmapped segments with an empty tlb
        repeat (n_unmapped)
            drive_pair(rand_bits(1), unmapped_addr(), rand_bits(1), rand_bits(1), unmapped_addr());
        drive_pair(1'b0, 32'h0, 1'b0, 1'b0, 32'h0);

        repeat (n_reg_loops) begin
            reg_write(wb_pkg::reg_index, rand_bits(32));
            reg_write(wb_pkg::reg_entryhi, rand_bits(32));
            reg_write(wb_pkg::reg_entrylo0, rand_bits(32));
            reg_write(wb_pkg::reg_entrylo1, rand_bits(32));
            reg_read_check(wb_pkg::reg_index, "Index readback");
            reg_read_check(wb_pkg::reg_entryhi, "EntryHi readback");
            reg_read_check(wb_pkg::reg_entrylo0, "EntryLo0 readback");
            reg_read_check(wb_pkg::reg_entrylo1, "EntryLo1 readback");
            reg_read_check(wb_pkg::reg_cmd, "command register readback");
        end

        for (int i = 0; i < 16; i++)
            write_entry(4'(i));

        for (int r = 0; r < n_rounds; r++) begin
            if (r % 2 == 1)
                write_entry(rand_bits(4));
            hi_vpn2 = rand_bits(19);
            hi_asid = rand_bits(2);
            reg_write(wb_pkg::reg_entryhi, {hi_vpn2, 11'b0, hi_asid});
            repeat (n_round_reqs)
                drive_pair(rand_bits(2) != 0, pick_addr(), rand_bits(2) != 0, rand_bits(1),
                           pick_addr());
            drive_pair(1'b0, 32'h0, 1'b0, 1'b0, 32'h0);
        end

        repeat (n_reads) begin
            reg_write(wb_pkg::reg_index, rand_bits(4));
            reg_write(wb_pkg::reg_cmd, wb_pkg::cmd_tlbr);
            reg_read_check(wb_pkg::reg_entryhi, "TLBR EntryHi");
            reg_read_check(wb_pkg::reg_entrylo0, "TLBR EntryLo0");
            reg_read_check(wb_pkg::reg_entrylo1, "TLBR EntryLo1");
        end

        for (int p = 0; p < n_probes; p++) begin
            probe_check(4'(p), 1'b1);
            probe_check(4'(p), 1'b0);
        end

        // valid on every cycle, both ports
        repeat (n_b2b)
            drive_pair(1'b1, pick_addr(), 1'b1, rand_bits(1), pick_addr());
        drive_pair(1'b0, 32'h0, 1'b0, 1'b0, 32'h0);
        repeat (4) @(posedge clk);
        if (inst_exp.size() != 0 || data_exp.size() != 0) begin
            fault_count++;
            $display("%0d fetch and %0d data responses never arrived",
                     inst_exp.size(), data_exp.size());
        end

        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, error_count, fault_count);
        if (error_count == 0 && fault_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule
